// ==== compile.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/axil_pkg.sv
verilog/dcache_way.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/dcache_chk.sv
bench/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench

SOURCES := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdcache_tb: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f compile.f

run: obj_dir/Vdcache_tb
	obj_dir/Vdcache_tb +verilator+error+limit+1000 | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log
	@! grep -q "SOME TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/dcache_tb.sv ====
// directed and random accesses through dcache_top; 64 KiB memory model, aligned word accesses only
`default_nettype none
`timescale 1ns/100ps

module dcache_tb
  import axil_pkg::*;
();

  logic clock;
  logic reset;
  axil_addr_t s_aw, s_ar, m_aw, m_ar;
  axil_w_t s_w, m_w;
  axil_b_t s_b, m_b;
  axil_r_t s_r, m_r;
  logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic s_arvalid, s_arready, s_rvalid, s_rready;
  logic m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  logic m_arvalid, m_arready, m_rvalid, m_rready;

  logic [31:0] rng = 32'hf9a;
  logic        bp;
  int          errors;
  int          cycles;

  // memory model and shadow copy with one 64-bit word per entry
  logic [63:0] mem [8192];
  logic [63:0] shadow [8192];
  logic        aw_got, w_got;
  logic [15:0] aw_addr, ar_addr, last_wr_addr;
  logic [63:0] w_data;
  int          wr_count, ar_count;

  // cache model holds tag, valid and dirty per way; the fill count drives the rotation
  logic [8:0] mtag [16][4];
  logic       mvalid [16][4];
  logic       mdirty [16][4];
  int         fills [16];
  int         rot [4] = '{0, 2, 1, 3};

  dcache_top i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic ready_bit();
    return !bp || (rand32() % 3 != 0);
  endfunction

  // every word differs and depends on all address bits
  function automatic logic [63:0] init_word(input logic [12:0] w);
    return {3'b101, w, ~w, 3'b010, 16'h5a00 ^ {w, 3'b111}, w * 13'h1b5, 3'b001};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clock) begin : mem_model
    logic b_done, r_done, ar_taken;
    b_done = m_bvalid && m_bready;
    r_done = m_rvalid && m_rready;
    ar_taken = m_arvalid && m_arready;
    if (ar_taken) ar_addr = m_ar.addr;
    if (m_awvalid && m_awready) begin
      aw_got = 1'b1;
      aw_addr = m_aw.addr;
    end
    if (m_wvalid && m_wready) begin
      w_got = 1'b1;
      w_data = m_w.data;
      // writebacks always carry a whole line
      check_value("m_w.strb", m_w.strb, 8'hff);
    end
    #1;
    if (b_done) m_bvalid = 1'b0;
    if (r_done) m_rvalid = 1'b0;
    if (aw_got && w_got && !m_bvalid) begin
      // a writeback must carry the latest processor value
      check_value("m_w.data", w_data, shadow[aw_addr[15:3]]);
      mem[aw_addr[15:3]] = w_data;
      last_wr_addr = aw_addr;
      wr_count++;
      aw_got = 1'b0;
      w_got = 1'b0;
      m_bvalid = 1'b1;
    end
    if (ar_taken) begin
      m_r.data = mem[ar_addr[15:3]];
      ar_count++;
      m_rvalid = 1'b1;
    end
    m_awready = !aw_got && ready_bit();
    m_wready = !w_got && ready_bit();
    m_arready = ready_bit();
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= 40000) begin
      $display("timeout: run did not finish within 40000 cycles");
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic cpu_read(input logic [15:0] addr, output logic [63:0] data);
    s_ar.addr = addr;
    s_arvalid = 1'b1;
    @(posedge clock);
    while (!s_arready) @(posedge clock);
    #1;
    s_arvalid = 1'b0;
    s_rready = ready_bit();
    @(posedge clock);
    while (!(s_rvalid && s_rready)) begin
      #1;
      s_rready = ready_bit();
      @(posedge clock);
    end
    data = s_r.data;
    check_value("s_r.resp", s_r.resp, AXIL_RESP_OKAY);
    #1;
    s_rready = 1'b0;
  endtask

  task automatic cpu_write(input logic [15:0] addr, input logic [63:0] data);
    s_aw.addr = addr;
    s_w.data = data;
    s_awvalid = 1'b1;
    s_wvalid = 1'b1;
    @(posedge clock);
    while (!(s_awready && s_wready)) @(posedge clock);
    #1;
    s_awvalid = 1'b0;
    s_wvalid = 1'b0;
    s_bready = ready_bit();
    @(posedge clock);
    while (!(s_bvalid && s_bready)) begin
      #1;
      s_bready = ready_bit();
      @(posedge clock);
    end
    check_value("s_b.resp", s_b.resp, AXIL_RESP_OKAY);
    #1;
    s_bready = 1'b0;
  endtask

  // predicts hit, victim and memory traffic, then runs the access and compares
  task automatic access(input logic is_write, input logic [8:0] tag, input logic [3:0] set,
                        input logic [63:0] wdata);
    logic [15:0] addr, exp_wb;
    logic [63:0] got;
    int hit_way, vway, wr0, ar0, exp_wr, exp_ar;
    addr = {tag, set, 3'b000};
    hit_way = -1;
    exp_wr = 0;
    exp_ar = 0;
    exp_wb = '0;
    for (int w = 0; w < 4; w++) begin
      if (mvalid[set][w] && mtag[set][w] == tag) hit_way = w;
    end
    if (hit_way < 0) begin
      vway = rot[fills[set] % 4];
      if (mvalid[set][vway] && mdirty[set][vway]) begin
        exp_wr = 1;
        exp_wb = {mtag[set][vway], set, 3'b000};
      end
      if (!is_write) exp_ar = 1;
      mtag[set][vway] = tag;
      mvalid[set][vway] = 1'b1;
      mdirty[set][vway] = is_write;
      fills[set]++;
    end else if (is_write) begin
      mdirty[set][hit_way] = 1'b1;
    end
    wr0 = wr_count;
    ar0 = ar_count;
    if (is_write) begin
      cpu_write(addr, wdata);
      shadow[addr[15:3]] = wdata;
    end else begin
      cpu_read(addr, got);
      check_value("s_r.data", got, shadow[addr[15:3]]);
    end
    check_value("memory write count", wr_count - wr0, exp_wr);
    check_value("memory read count", ar_count - ar0, exp_ar);
    if (exp_wr == 1) check_value("m_aw.addr", last_wr_addr, exp_wb);
    if (exp_ar == 1) check_value("m_ar.addr", ar_addr, addr);
  endtask

  task automatic random_mix(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = rand32();
      access(r[5], {6'd0, r[4:2]}, {2'd0, r[1:0]}, {rand32(), rand32()});
    end
  endtask

  initial begin
    reset = 1'b1;
    bp = 1'b0;
    errors = 0;
    cycles = 0;
    wr_count = 0;
    ar_count = 0;
    aw_got = 1'b0;
    w_got = 1'b0;
    s_aw = '0;
    s_w = '{data: '0, strb: 8'hff};
    s_ar = '0;
    {s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready} = '0;
    {m_awready, m_wready, m_bvalid, m_arready, m_rvalid} = '0;
    m_b.resp = AXIL_RESP_OKAY;
    m_r = '{data: '0, resp: AXIL_RESP_OKAY};
    for (int a = 0; a < 8192; a++) begin
      mem[a] = init_word(a[12:0]);
      shadow[a] = init_word(a[12:0]);
    end
    for (int s = 0; s < 16; s++) begin
      fills[s] = 0;
      for (int w = 0; w < 4; w++) begin
        mtag[s][w] = '0;
        mvalid[s][w] = 1'b0;
        mdirty[s][w] = 1'b0;
      end
    end
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    // read miss, then a hit on the same word
    access(1'b0, 9'h001, 4'd0, '0);
    access(1'b0, 9'h001, 4'd0, '0);
    // write hit, read back, then evict the dirty line
    access(1'b0, 9'h002, 4'd3, '0);
    access(1'b1, 9'h002, 4'd3, 64'hfeed_0123_4567_89ab);
    access(1'b0, 9'h002, 4'd3, '0);
    for (int t = 3; t < 7; t++) access(1'b1, t[8:0], 4'd3, {32'hd00d, t});
    // eight dirty tags in one set
    for (int t = 'h20; t < 'h28; t++) access(1'b1, t[8:0], 4'd7, {32'hc0de, t});
    // clean evictions, then a write miss over a clean victim
    for (int t = 'h30; t < 'h38; t++) access(1'b0, t[8:0], 4'd9, '0);
    access(1'b1, 9'h038, 4'd9, 64'h1111_2222_3333_4444);
    // stalls on both sides
    bp = 1'b1;
    random_mix(150);
    bp = 1'b0;
    random_mix(300);

    repeat (4) @(posedge clock);
    $display("errors: %0d value checks, %0d assertion failures",
             errors, i_dut.i_chk.failures);
    if (errors == 0 && i_dut.i_chk.failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/dcache_chk.sv ====
// protocol and hit latency checks on dcache_top; hit latency holds only with no memory traffic
`default_nettype none
`timescale 1ns/100ps

module dcache_chk
  import axil_pkg::*;
(
  input wire logic       clock,
  input wire logic       reset,
  input wire axil_addr_t m_aw,
  input wire axil_w_t    m_w,
  input wire axil_addr_t m_ar,
  input wire axil_r_t    s_r,
  input wire axil_b_t    s_b,
  input wire logic       s_awvalid, s_awready, s_wready, s_bvalid, s_bready,
  input wire logic       s_arvalid, s_arready, s_rvalid, s_rready,
  input wire logic       m_awvalid, m_awready, m_wvalid, m_wready, m_bready,
  input wire logic       m_arvalid, m_arready, m_rready
);

  int failures = 0;

  logic busy;
  logic any_ready;
  assign busy = s_rvalid || s_bvalid || m_awvalid || m_wvalid || m_bready || m_arvalid || m_rready;
  assign any_ready = s_arready || s_awready || s_wready;

  a_reset_quiet: assert property (@(posedge clock)
    reset |=> !(s_rvalid || s_bvalid || m_awvalid || m_wvalid || m_arvalid))
    else begin failures++; $error("valid raised right after reset"); end

  a_aw_stable: assert property (@(posedge clock) disable iff (reset)
    m_awvalid && !m_awready |=> m_awvalid && $stable(m_aw))
    else begin failures++; $error("m_aw dropped or changed while stalled"); end

  a_w_stable: assert property (@(posedge clock) disable iff (reset)
    m_wvalid && !m_wready |=> m_wvalid && $stable(m_w))
    else begin failures++; $error("m_w dropped or changed while stalled"); end

  a_ar_stable: assert property (@(posedge clock) disable iff (reset)
    m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar))
    else begin failures++; $error("m_ar dropped or changed while stalled"); end

  a_r_stable: assert property (@(posedge clock) disable iff (reset)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_r))
    else begin failures++; $error("s_r dropped or changed while stalled"); end

  a_b_stable: assert property (@(posedge clock) disable iff (reset)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_b))
    else begin failures++; $error("s_b dropped or changed while stalled"); end

  a_busy_ready: assert property (@(posedge clock) disable iff (reset)
    busy |-> !any_ready)
    else begin failures++; $error("processor ready high outside idle"); end

  a_taken_ready: assert property (@(posedge clock) disable iff (reset)
    (s_arvalid && s_arready) || (s_awvalid && s_awready) |=> !any_ready)
    else begin failures++; $error("processor ready high during lookup"); end

  a_read_hit: assert property (@(posedge clock) disable iff (reset)
    $past(s_arvalid && s_arready, 2) && !m_arvalid && !m_awvalid |-> s_rvalid)
    else begin failures++; $error("read hit response not two cycles after request"); end

  a_write_hit: assert property (@(posedge clock) disable iff (reset)
    $past(s_awvalid && s_awready, 2) && !m_awvalid |-> s_bvalid)
    else begin failures++; $error("write response not two cycles after request"); end

endmodule

bind dcache_top dcache_chk i_chk (
  .clock(clock), .reset(reset), .m_aw(m_aw), .m_w(m_w), .m_ar(m_ar), .s_r(s_r), .s_b(s_b),
  .s_awvalid(s_awvalid), .s_awready(s_awready), .s_wready(s_wready),
  .s_bvalid(s_bvalid), .s_bready(s_bready), .s_arvalid(s_arvalid), .s_arready(s_arready),
  .s_rvalid(s_rvalid), .s_rready(s_rready), .m_awvalid(m_awvalid), .m_awready(m_awready),
  .m_wvalid(m_wvalid), .m_wready(m_wready), .m_bready(m_bready), .m_arvalid(m_arvalid),
  .m_arready(m_arready), .m_rready(m_rready)
);

`default_nettype wire

// ==== verilog/dcache_top.sv ====
// write-back L1 data cache between an AXI4-Lite slave and master; single word lines only
`default_nettype none
`timescale 1ns/100ps

module dcache_top
  import dcache_pkg::*, axil_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  axil_addr_t s_aw,
  input  logic       s_awvalid,
  output logic       s_awready,
  input  axil_w_t    s_w,
  input  logic       s_wvalid,
  output logic       s_wready,
  output axil_b_t    s_b,
  output logic       s_bvalid,
  input  logic       s_bready,
  input  axil_addr_t s_ar,
  input  logic       s_arvalid,
  output logic       s_arready,
  output axil_r_t    s_r,
  output logic       s_rvalid,
  input  logic       s_rready,
  output axil_addr_t m_aw,
  output logic       m_awvalid,
  input  logic       m_awready,
  output axil_w_t    m_w,
  output logic       m_wvalid,
  input  logic       m_wready,
  input  axil_b_t    m_b,
  input  logic       m_bvalid,
  output logic       m_bready,
  output axil_addr_t m_ar,
  output logic       m_arvalid,
  input  logic       m_arready,
  input  axil_r_t    m_r,
  input  logic       m_rvalid,
  output logic       m_rready
);

  cache_addr_t lookup_addr;
  array_op_e   op;
  logic [63:0] store_data;
  logic        store_dirty;
  logic        hit;
  logic [63:0] hit_data;
  victim_t     victim;

  dcache_ctrl i_ctrl (
    .clock(clock), .reset(reset),
    .hit(hit), .hit_data(hit_data), .victim(victim),
    .lookup_addr(lookup_addr), .op(op), .store_data(store_data), .store_dirty(store_dirty),
    .s_aw(s_aw), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .s_w(s_w), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .s_b(s_b), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .s_ar(s_ar), .s_arvalid(s_arvalid), .s_arready(s_arready),
    .s_r(s_r), .s_rvalid(s_rvalid), .s_rready(s_rready),
    .m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready),
    .m_b(m_b), .m_bvalid(m_bvalid), .m_bready(m_bready),
    .m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
    .m_r(m_r), .m_rvalid(m_rvalid), .m_rready(m_rready)
  );

  dcache_array i_array (
    .clock       (clock),
    .reset       (reset),
    .lookup_addr (lookup_addr),
    .op          (op),
    .store_data  (store_data),
    .store_dirty (store_dirty),
    .hit         (hit),
    .hit_data    (hit_data),
    .victim      (victim)
  );

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
// one request at a time; write strobes and prot are ignored and every response is OKAY
`default_nettype none
`timescale 1ns/100ps

module dcache_ctrl
  import dcache_pkg::*, axil_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        hit,
  input  logic [63:0] hit_data,
  input  victim_t     victim,
  output cache_addr_t lookup_addr,
  output array_op_e   op,
  output logic [63:0] store_data,
  output logic        store_dirty,
  input  axil_addr_t  s_aw,
  input  logic        s_awvalid,
  output logic        s_awready,
  input  axil_w_t     s_w,
  input  logic        s_wvalid,
  output logic        s_wready,
  output axil_b_t     s_b,
  output logic        s_bvalid,
  input  logic        s_bready,
  input  axil_addr_t  s_ar,
  input  logic        s_arvalid,
  output logic        s_arready,
  output axil_r_t     s_r,
  output logic        s_rvalid,
  input  logic        s_rready,
  output axil_addr_t  m_aw,
  output logic        m_awvalid,
  input  logic        m_awready,
  output axil_w_t     m_w,
  output logic        m_wvalid,
  input  logic        m_wready,
  input  axil_b_t     m_b,
  input  logic        m_bvalid,
  output logic        m_bready,
  output axil_addr_t  m_ar,
  output logic        m_arvalid,
  input  logic        m_arready,
  input  axil_r_t     m_r,
  input  logic        m_rvalid,
  output logic        m_rready
);

  ctrl_state_e state;
  ctrl_state_e state_next;
  cache_addr_t req_addr;
  logic        req_write;
  logic [63:0] req_data;
  logic [63:0] resp_data;
  logic        aw_done;
  logic        w_done;
  logic        wb_needed;
  logic        wb_sent;

  // reads win; a write needs AW and W together
  assign s_arready = (state == ST_IDLE);
  assign s_awready = (state == ST_IDLE) && !s_arvalid && s_wvalid;
  assign s_wready  = (state == ST_IDLE) && !s_arvalid && s_awvalid;

  assign wb_needed = victim.valid && victim.dirty;
  assign wb_sent   = (aw_done || m_awready) && (w_done || m_wready);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:        if (s_arvalid || (s_awvalid && s_wvalid)) state_next = ST_LOOKUP;
      ST_LOOKUP: begin
        if (hit) state_next = ST_RESPOND;
        else if (wb_needed) state_next = ST_WB_ADDR;
        else if (req_write) state_next = ST_RESPOND;
        else state_next = ST_REFILL_ADDR;
      end
      ST_WB_ADDR:     if (wb_sent) state_next = ST_WB_RESP;
      ST_WB_RESP:     if (m_bvalid) state_next = req_write ? ST_RESPOND : ST_REFILL_ADDR;
      ST_REFILL_ADDR: if (m_arready) state_next = ST_REFILL_DATA;
      ST_REFILL_DATA: if (m_rvalid) state_next = ST_RESPOND;
      ST_RESPOND:     if (req_write ? s_bready : s_rready) state_next = ST_IDLE;
      default:        state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= ST_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      state <= state_next;
      // AW and W may complete on different edges
      if (state == ST_WB_ADDR && !wb_sent) begin
        aw_done <= aw_done || m_awready;
        w_done  <= w_done || m_wready;
      end else begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
    end
  end

  // request capture and response data
  always_ff @(posedge clock) begin
    if (state == ST_IDLE) begin
      if (s_arvalid) begin
        req_addr  <= cache_addr_t'(s_ar.addr);
        req_write <= 1'b0;
      end else if (s_awvalid && s_wvalid) begin
        req_addr  <= cache_addr_t'(s_aw.addr);
        req_data  <= s_w.data;
        req_write <= 1'b1;
      end
    end
    if (state == ST_LOOKUP && hit) begin
      resp_data <= hit_data;
    end
    if (state == ST_REFILL_DATA && m_rvalid) begin
      resp_data <= m_r.data;
    end
  end

  always_comb begin
    op = ARRAY_NONE;
    case (state)
      ST_LOOKUP: begin
        if (req_write && hit) op = ARRAY_STORE;
        else if (req_write && !wb_needed) op = ARRAY_FILL;
      end
      ST_WB_RESP:     if (m_bvalid && req_write) op = ARRAY_FILL;
      ST_REFILL_DATA: if (m_rvalid) op = ARRAY_FILL;
      default:        op = ARRAY_NONE;
    endcase
  end

  // writes install dirty, refills clean
  assign lookup_addr = req_addr;
  assign store_data  = req_write ? req_data : m_r.data;
  assign store_dirty = req_write;

  assign s_rvalid = (state == ST_RESPOND) && !req_write;
  assign s_r.data = resp_data;
  assign s_r.resp = AXIL_RESP_OKAY;
  assign s_bvalid = (state == ST_RESPOND) && req_write;
  assign s_b.resp = AXIL_RESP_OKAY;

  // victim stays put while the array is idle
  assign m_awvalid   = (state == ST_WB_ADDR) && !aw_done;
  assign m_aw.addr   = victim.addr;
  assign m_aw.prot   = 3'b000;
  assign m_wvalid    = (state == ST_WB_ADDR) && !w_done;
  assign m_w.data    = victim.data;
  assign m_w.strb    = 8'hff;
  assign m_bready    = (state == ST_WB_RESP);
  assign m_arvalid   = (state == ST_REFILL_ADDR);
  assign m_ar.addr   = {req_addr.tag, req_addr.index, 3'b000};
  assign m_ar.prot   = 3'b000;
  assign m_rready    = (state == ST_REFILL_DATA);

endmodule

`default_nettype wire

// ==== verilog/dcache_array.sv ====
// four-way array; the tree only advances on fills, so victims rotate 0,2,1,3 per set
`default_nettype none
`timescale 1ns/100ps

`include "dcache_cfg.svh"

module dcache_array
  import dcache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  cache_addr_t lookup_addr,
  input  array_op_e   op,
  input  logic [63:0] store_data,
  input  logic        store_dirty,
  output logic        hit,
  output logic [63:0] hit_data,
  output victim_t     victim
);

  // tree bits per set: root picks the pair, low and high pick within it
  logic [`DCACHE_SETS-1:0] tree_root;
  logic [`DCACHE_SETS-1:0] tree_low;
  logic [`DCACHE_SETS-1:0] tree_high;

  logic [`DCACHE_WAYS-1:0] way_hit;
  logic [`DCACHE_WAYS-1:0] way_we;
  cache_line_t             way_line [`DCACHE_WAYS];
  cache_line_t             write_line;
  cache_line_t             victim_line;
  logic [1:0]              victim_way;
  logic                    root_bit;

  assign root_bit   = tree_root[lookup_addr.index];
  assign victim_way = root_bit ? {1'b1, tree_high[lookup_addr.index]}
                               : {1'b0, tree_low[lookup_addr.index]};

  always_ff @(posedge clock) begin
    if (reset) begin
      tree_root <= '0;
      tree_low  <= '0;
      tree_high <= '0;
    end else if (op == ARRAY_FILL) begin
      tree_root[lookup_addr.index] <= ~root_bit;
      // flip only the side that chose this victim
      if (root_bit) begin
        tree_high[lookup_addr.index] <= ~tree_high[lookup_addr.index];
      end else begin
        tree_low[lookup_addr.index] <= ~tree_low[lookup_addr.index];
      end
    end
  end

  // same line image for store and fill, tag taken from the address
  assign write_line.valid = 1'b1;
  assign write_line.dirty = store_dirty;
  assign write_line.tag   = lookup_addr.tag;
  assign write_line.data  = store_data;

  always_comb begin
    way_we = '0;
    case (op)
      ARRAY_STORE: way_we = way_hit;
      ARRAY_FILL:  way_we[victim_way] = 1'b1;
      default:     way_we = '0;
    endcase
  end

  for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
    dcache_way i_way (
      .clock       (clock),
      .reset       (reset),
      .lookup_addr (lookup_addr),
      .write_en    (way_we[w]),
      .write_line  (write_line),
      .hit         (way_hit[w]),
      .line        (way_line[w])
    );
  end

  assign hit = |way_hit;

  // at most one way matches a tag
  always_comb begin
    hit_data = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_data = way_line[w].data;
      end
    end
  end

  assign victim_line = way_line[victim_way];

  assign victim.valid = victim_line.valid;
  assign victim.dirty = victim_line.dirty;
  assign victim.addr  = {victim_line.tag, lookup_addr.index, 3'b000};
  assign victim.data  = victim_line.data;

endmodule

`default_nettype wire

// ==== verilog/dcache_way.sv ====
// one cache way; lookup is combinational and a write lands on the next edge
`default_nettype none
`timescale 1ns/100ps

`include "dcache_cfg.svh"

module dcache_way
  import dcache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  cache_addr_t lookup_addr,
  input  logic        write_en,
  input  cache_line_t write_line,
  output logic        hit,
  output cache_line_t line
);

  // state bits under reset
  logic [`DCACHE_SETS-1:0] valid_bits;
  logic [`DCACHE_SETS-1:0] dirty_bits;

  // tag and data storage
  logic [`DCACHE_TAG_BITS-1:0] tag_mem [`DCACHE_SETS];
  logic [63:0]                 data_mem [`DCACHE_SETS];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (write_en) begin
      valid_bits[lookup_addr.index] <= write_line.valid;
      dirty_bits[lookup_addr.index] <= write_line.dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (write_en) begin
      tag_mem[lookup_addr.index]  <= write_line.tag;
      data_mem[lookup_addr.index] <= write_line.data;
    end
  end

  // indexed line, also used as the victim candidate
  assign line.valid = valid_bits[lookup_addr.index];
  assign line.dirty = dirty_bits[lookup_addr.index];
  assign line.tag   = tag_mem[lookup_addr.index];
  assign line.data  = data_mem[lookup_addr.index];

  assign hit = line.valid && (line.tag == lookup_addr.tag);

endmodule

`default_nettype wire

// ==== verilog/axil_pkg.sv ====
// AXI4-Lite payloads for a 64-bit data bus; address width follows the cache cfg header
`default_nettype none

`include "dcache_cfg.svh"

package axil_pkg;

  typedef enum logic [1:0] {
    AXIL_RESP_OKAY   = 2'b00,
    AXIL_RESP_EXOKAY = 2'b01,
    AXIL_RESP_SLVERR = 2'b10,
    AXIL_RESP_DECERR = 2'b11
  } axil_resp_e;

  // shared by AW and AR
  typedef struct packed {
    logic [`DCACHE_ADDR_BITS-1:0] addr;
    logic [2:0]                   prot;
  } axil_addr_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
  } axil_w_t;

  typedef struct packed {
    logic [63:0] data;
    axil_resp_e  resp;
  } axil_r_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
// cache-side types for single-word 64-bit lines; widths come from the cfg header
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

  // byte address as seen by the array
  typedef struct packed {
    logic [`DCACHE_TAG_BITS-1:0]   tag;
    logic [`DCACHE_INDEX_BITS-1:0] index;
    logic [2:0]                    offset;
  } cache_addr_t;

  typedef struct packed {
    logic                        valid;
    logic                        dirty;
    logic [`DCACHE_TAG_BITS-1:0] tag;
    logic [63:0]                 data;
  } cache_line_t;

  // line the tree would evict, with its address rebuilt
  typedef struct packed {
    logic        valid;
    logic        dirty;
    cache_addr_t addr;
    logic [63:0] data;
  } victim_t;

  typedef enum logic [1:0] {ARRAY_NONE, ARRAY_STORE, ARRAY_FILL} array_op_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_LOOKUP, ST_WB_ADDR, ST_WB_RESP, ST_REFILL_ADDR, ST_REFILL_DATA, ST_RESPOND
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/dcache_cfg.svh ====
// cache sizes; DCACHE_SETS must be a power of two and the way count stays at 4 for the tree
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address width on both ports
`define DCACHE_ADDR_BITS 16

// lines per way
`define DCACHE_SETS 16

// set index width
`define DCACHE_INDEX_BITS $clog2(`DCACHE_SETS)

// tag is what remains above index and the 3-bit byte offset
`define DCACHE_TAG_BITS (`DCACHE_ADDR_BITS - `DCACHE_INDEX_BITS - 3)

// replacement tree is built for exactly four ways
`define DCACHE_WAYS 4

`endif
